// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= ALL CHECKS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$($(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
id_pkg.sv
inst_decoder.sv
operand_select.sv
branch_unit.sv
id_ex_reg.sv
id_stage.sv
id_stage_assert.sv
tb_id_stage.sv

// File: branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
  input  id_pkg::br_kind_e br_kind_i,
  input  id_pkg::word_t    pc_i,
  input  id_pkg::word_t    inst_i,
  input  id_pkg::word_t    reg1_i,
  input  id_pkg::word_t    reg2_i,
  output id_pkg::branch_t  branch_o,
  output id_pkg::word_t    link_addr_o,
  output logic             next_in_delayslot_o
);
  import id_pkg::*;

  word_t pc_plus_4;
  word_t pc_plus_8;
  word_t jump_target;
  word_t rel_target;
  word_t offset;
  logic  taken;

  assign pc_plus_4   = pc_i + PC_NEXT_OFFSET;
  assign pc_plus_8   = pc_i + PC_LINK_OFFSET;
  assign offset      = {{(32 - IMM_WIDTH - 2){inst_i[IMM_WIDTH-1]}},
                        inst_i[IMM_WIDTH-1:0], 2'b00};
  assign jump_target = {pc_plus_4[31:28], inst_i[JUMP_INDEX_WIDTH-1:0], 2'b00};
  assign rel_target  = pc_plus_4 + offset;

  always_comb begin
    taken           = 1'b0;
    branch_o.target = '0;
    case (br_kind_i)
      BR_J, BR_JAL: begin
        taken           = 1'b1;
        branch_o.target = jump_target;
      end
      BR_JR, BR_JALR: begin
        taken           = 1'b1;
        branch_o.target = reg1_i;
      end
      BR_BEQ:  taken = (reg1_i == reg2_i);
      BR_BNE:  taken = (reg1_i != reg2_i);
      BR_BGTZ: taken = !reg1_i[31] && (reg1_i != '0);
      BR_BLEZ: taken = reg1_i[31] || (reg1_i == '0);
      BR_BGEZ: taken = !reg1_i[31];
      BR_BLTZ: taken = reg1_i[31];
      default: ;
    endcase
    if (taken && !(br_kind_i inside {BR_J, BR_JAL, BR_JR, BR_JALR})) begin
      branch_o.target = rel_target;  // conditional branch, pc relative
    end
  end

  assign branch_o.flag       = taken;
  assign next_in_delayslot_o = taken;  // instruction after a taken branch is the slot
  assign link_addr_o = (br_kind_i inside {BR_JAL, BR_JALR}) ? pc_plus_8 : '0;

endmodule

`default_nettype wire

// File: id_ex_reg.sv
`timescale 1ns/1ns
`default_nettype none

module id_ex_reg (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             stall_i,
  input  id_pkg::ex_ctrl_t ctrl_i,
  output id_pkg::ex_ctrl_t ctrl_o
);
  import id_pkg::*;

  logic bubble;

  assign bubble = rst_i || stall_i;

  // control fields, cleared into a bubble
  always_ff @(posedge clk_i) begin
    if (bubble) begin
      ctrl_o.aluop        <= ALU_NOP;
      ctrl_o.alusel       <= SEL_NOP;
      ctrl_o.wreg         <= 1'b0;
      ctrl_o.in_delayslot <= 1'b0;
    end else begin
      ctrl_o.aluop        <= ctrl_i.aluop;
      ctrl_o.alusel       <= ctrl_i.alusel;
      ctrl_o.wreg         <= ctrl_i.wreg;
      ctrl_o.in_delayslot <= ctrl_i.in_delayslot;
    end
  end

  // payload, meaningless under a bubble
  always_ff @(posedge clk_i) begin
    ctrl_o.reg1      <= ctrl_i.reg1;
    ctrl_o.reg2      <= ctrl_i.reg2;
    ctrl_o.wd        <= ctrl_i.wd;
    ctrl_o.link_addr <= ctrl_i.link_addr;
    ctrl_o.inst      <= ctrl_i.inst;
  end

endmodule

`default_nettype wire

// File: id_pkg.sv
`default_nettype none

package id_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  localparam reg_addr_t LINK_REG = 5'd31;
  localparam reg_addr_t NOP_REG  = 5'd0;

  localparam word_t PC_LINK_OFFSET = 32'd8;
  localparam word_t PC_NEXT_OFFSET = 32'd4;

  // instruction field positions
  localparam int OPCODE_LSB       = 26;
  localparam int RS_LSB           = 21;
  localparam int RT_LSB           = 16;
  localparam int RD_LSB           = 11;
  localparam int SHAMT_LSB        = 6;
  localparam int IMM_WIDTH        = 16;
  localparam int JUMP_INDEX_WIDTH = 26;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001, OP_J     = 6'b000010,
    OP_JAL     = 6'b000011, OP_BEQ    = 6'b000100, OP_BNE   = 6'b000101,
    OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111, OP_ADDI  = 6'b001000,
    OP_ADDIU   = 6'b001001, OP_ANDI   = 6'b001100, OP_ORI   = 6'b001101,
    OP_XORI    = 6'b001110, OP_LUI    = 6'b001111, OP_LW    = 6'b100011,
    OP_SW      = 6'b101011
  } opcode_e;

  typedef enum logic [5:0] {
    FN_SLL  = 6'b000000, FN_SRL  = 6'b000010, FN_SRA  = 6'b000011,
    FN_SLLV = 6'b000100, FN_SRLV = 6'b000110, FN_SRAV = 6'b000111,
    FN_JR   = 6'b001000, FN_JALR = 6'b001001, FN_ADD  = 6'b100000,
    FN_ADDU = 6'b100001, FN_SUB  = 6'b100010, FN_AND  = 6'b100100,
    FN_OR   = 6'b100101, FN_XOR  = 6'b100110, FN_SLT  = 6'b101010
  } funct_e;

  typedef enum logic [4:0] {
    RI_BLTZ = 5'b00000,
    RI_BGEZ = 5'b00001
  } regimm_e;

  typedef enum logic [7:0] {
    ALU_NOP  = 8'b00000000, ALU_AND   = 8'b00100100, ALU_OR   = 8'b00100101,
    ALU_XOR  = 8'b00100110, ALU_SLL   = 8'b01111100, ALU_SRL  = 8'b00000010,
    ALU_SRA  = 8'b00000011, ALU_SLT   = 8'b00101010, ALU_ADD  = 8'b00100000,
    ALU_ADDU = 8'b00100001, ALU_SUB   = 8'b00100010, ALU_ADDI = 8'b01010101,
    ALU_ADDIU = 8'b01010110, ALU_J    = 8'b01001111, ALU_JAL  = 8'b01010000,
    ALU_JALR = 8'b00001001, ALU_JR    = 8'b00001000, ALU_BEQ  = 8'b01010001,
    ALU_BGEZ = 8'b01000001, ALU_BGTZ  = 8'b01010100, ALU_BLEZ = 8'b01010011,
    ALU_BLTZ = 8'b01000000, ALU_BNE   = 8'b01010010, ALU_LW   = 8'b11100011,
    ALU_SW   = 8'b11101011
  } aluop_e;

  typedef enum logic [2:0] {
    SEL_NOP = 3'b000, SEL_LOGIC = 3'b001, SEL_SHIFT = 3'b010,
    SEL_ARITH = 3'b100, SEL_JB = 3'b110, SEL_LDST = 3'b111
  } alusel_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_J, BR_JAL, BR_JR, BR_JALR, BR_BEQ,
    BR_BNE, BR_BGTZ, BR_BLEZ, BR_BGEZ, BR_BLTZ
  } br_kind_e;

  typedef struct packed {
    logic      re1;
    logic      re2;
    reg_addr_t addr1;
    reg_addr_t addr2;
  } rf_read_t;

  typedef struct packed {
    logic      wreg;
    reg_addr_t wd;
    word_t     wdata;
  } fwd_t;

  typedef struct packed {
    fwd_t   fwd;
    aluop_e aluop;  // lets decode spot a load in execute
  } ex_fwd_t;

  typedef struct packed {
    logic  flag;
    word_t target;
  } branch_t;

  // decoder control fields, shared by decoder and top level
  typedef struct packed {
    aluop_e    aluop;
    alusel_e   alusel;
    reg_addr_t wd;
    logic      wreg;
  } dec_t;

  typedef struct packed {
    aluop_e    aluop;
    alusel_e   alusel;
    word_t     reg1;
    word_t     reg2;
    reg_addr_t wd;
    logic      wreg;
    word_t     link_addr;
    logic      in_delayslot;
    word_t     inst;  // store offset travels on in here
  } ex_ctrl_t;

endpackage

`default_nettype wire

// File: id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
  input  logic                clk_i,
  input  logic                rst_i,
  input  id_pkg::word_t       pc_i,
  input  id_pkg::word_t       inst_i,
  input  id_pkg::word_t [1:0] rf_data_i,
  input  id_pkg::ex_fwd_t     ex_fwd_i,
  input  id_pkg::fwd_t        mem_fwd_i,
  input  logic                in_delayslot_i,
  output id_pkg::rf_read_t    rf_read_o,
  output logic                stall_o,
  output id_pkg::branch_t     branch_o,
  output logic                next_in_delayslot_o,
  output id_pkg::ex_ctrl_t    ex_o
);
  import id_pkg::*;

  dec_t     dec;
  word_t    imm;
  br_kind_e br_kind;
  word_t    reg1;
  word_t    reg2;
  word_t    link_addr;
  ex_ctrl_t ex_ctrl;

  inst_decoder u_dec (
    .inst_i    (inst_i),
    .dec_o     (dec),
    .rf_read_o (rf_read_o),
    .imm_o     (imm),
    .br_kind_o (br_kind)
  );

  operand_select u_opsel (
    .rf_read_i (rf_read_o),
    .imm_i     (imm),
    .rf_data_i (rf_data_i),
    .ex_fwd_i  (ex_fwd_i),
    .mem_fwd_i (mem_fwd_i),
    .reg1_o    (reg1),
    .reg2_o    (reg2),
    .stall_o   (stall_o)
  );

  branch_unit u_br (
    .br_kind_i           (br_kind),
    .pc_i                (pc_i),
    .inst_i              (inst_i),
    .reg1_i              (reg1),
    .reg2_i              (reg2),
    .branch_o            (branch_o),
    .link_addr_o         (link_addr),
    .next_in_delayslot_o (next_in_delayslot_o)
  );

  assign ex_ctrl = '{aluop: dec.aluop, alusel: dec.alusel, reg1: reg1, reg2: reg2,
                     wd: dec.wd, wreg: dec.wreg, link_addr: link_addr,
                     in_delayslot: in_delayslot_i, inst: inst_i};

  id_ex_reg u_idex (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .stall_i (stall_o),
    .ctrl_i  (ex_ctrl),
    .ctrl_o  (ex_o)
  );

endmodule

`default_nettype wire

// File: id_stage_assert.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage_assert (
  input logic             clk_i,
  input logic             rst_i,
  input id_pkg::word_t    pc_i,
  input id_pkg::word_t    inst_i,
  input id_pkg::ex_fwd_t  ex_fwd_i,
  input id_pkg::fwd_t     mem_fwd_i,
  input logic             stall_i,
  input id_pkg::branch_t  branch_i,
  input logic             next_in_delayslot_i,
  input id_pkg::ex_ctrl_t ex_i
);
  import id_pkg::*;

  int          fail_count = 0;  // read by the testbench
  logic [5:0]  op;
  logic [5:0]  fn;
  reg_addr_t   rs;
  reg_addr_t   rt;
  logic [10:0] exp_rt;  // {aluop, alusel}
  logic        is_shift;
  logic        is_rtype;
  logic        is_imm;
  logic        reads_rt;
  logic        exp_stall;
  logic        exp_flag;
  word_t       a;
  word_t       b;
  word_t       pc4;
  word_t       exp_r1;
  word_t       exp_imm;
  word_t       exp_target;

  function automatic logic [10:0] rtype_ctrl(input logic [5:0] f);
    case (f)
      FN_OR:   return {ALU_OR, SEL_LOGIC};
      FN_AND:  return {ALU_AND, SEL_LOGIC};
      FN_XOR:  return {ALU_XOR, SEL_LOGIC};
      FN_SLLV: return {ALU_SLL, SEL_SHIFT};
      FN_SRLV: return {ALU_SRL, SEL_SHIFT};
      FN_SRAV: return {ALU_SRA, SEL_SHIFT};
      FN_SLL:  return {ALU_SLL, SEL_SHIFT};
      FN_SRL:  return {ALU_SRL, SEL_SHIFT};
      FN_SRA:  return {ALU_SRA, SEL_SHIFT};
      FN_SLT:  return {ALU_SLT, SEL_ARITH};
      FN_ADD:  return {ALU_ADD, SEL_ARITH};
      FN_ADDU: return {ALU_ADDU, SEL_ARITH};
      FN_SUB:  return {ALU_SUB, SEL_ARITH};
      default: return {ALU_NOP, SEL_NOP};
    endcase
  endfunction

  // execute first, then memory, then the register file value
  function automatic word_t operand(input reg_addr_t addr);
    if (ex_fwd_i.fwd.wreg && ex_fwd_i.fwd.wd == addr) return ex_fwd_i.fwd.wdata;
    if (mem_fwd_i.wreg && mem_fwd_i.wd == addr) return mem_fwd_i.wdata;
    return 32'h1000_0000 + {27'd0, addr};
  endfunction

  always_comb begin
    op       = inst_i[31:26];
    fn       = inst_i[5:0];
    rs       = inst_i[25:21];
    rt       = inst_i[20:16];
    a        = operand(rs);
    b        = operand(rt);
    exp_rt   = rtype_ctrl(fn);
    is_shift = inst_i[31:21] == '0 && fn inside {FN_SLL, FN_SRL, FN_SRA};
    is_rtype = is_shift || (op == OP_SPECIAL && inst_i[10:6] == '0 && exp_rt != '0 &&
               !(fn inside {FN_SLL, FN_SRL, FN_SRA}));
    exp_r1   = is_shift ? {27'd0, inst_i[10:6]} : a;
    is_imm   = op inside {OP_ORI, OP_ANDI, OP_XORI, OP_ADDI, OP_ADDIU, OP_LUI};
    exp_imm  = {16'h0, inst_i[15:0]};
    if (op inside {OP_ADDI, OP_ADDIU}) exp_imm = {{16{inst_i[15]}}, inst_i[15:0]};
    if (op == OP_LUI) exp_imm = {inst_i[15:0], 16'h0};
    reads_rt  = is_rtype || op inside {OP_BEQ, OP_BNE, OP_SW};
    exp_stall = ex_fwd_i.aluop == ALU_LW && ex_fwd_i.fwd.wreg &&
                ((!is_shift && !(op inside {OP_J, OP_JAL}) && rs == ex_fwd_i.fwd.wd) ||
                 (reads_rt && rt == ex_fwd_i.fwd.wd));
    pc4        = pc_i + 32'd4;
    exp_flag   = 1'b0;
    exp_target = pc4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
    case (op)
      OP_J, OP_JAL: exp_flag = 1'b1;
      OP_BEQ:       exp_flag = a == b;
      OP_BNE:       exp_flag = a != b;
      OP_BGTZ:      exp_flag = !a[31] && a != '0;
      OP_BLEZ:      exp_flag = a[31] || a == '0;
      OP_REGIMM:    exp_flag = (rt == RI_BGEZ) ? !a[31] : a[31];
      OP_SPECIAL:   exp_flag = fn inside {FN_JR, FN_JALR} && inst_i[10:6] == '0;
      default: ;
    endcase
    if (op inside {OP_J, OP_JAL}) exp_target = {pc4[31:28], inst_i[25:0], 2'b00};
    if (op == OP_SPECIAL) exp_target = a;  // register jumps
  end

  assert property (@(posedge clk_i) disable iff (rst_i) is_rtype && !stall_i |=>
      {ex_i.aluop, ex_i.alusel} == $past(exp_rt) && ex_i.wd == $past(inst_i[15:11]) &&
      ex_i.wreg && ex_i.reg1 == $past(exp_r1) && ex_i.reg2 == $past(b))
    else begin
      fail_count++;
      $error("Mismatch at %0t: R-type bundle in execute", $time);
    end

  assert property (@(posedge clk_i) disable iff (rst_i) is_imm && !stall_i |=>
      ex_i.reg1 == $past(a) && ex_i.reg2 == $past(exp_imm) && ex_i.wd == $past(rt) &&
      ex_i.wreg)
    else begin
      fail_count++;
      $error("Mismatch at %0t: immediate operand or destination", $time);
    end

  assert property (@(posedge clk_i) branch_i.flag == exp_flag &&
      next_in_delayslot_i == exp_flag && (!exp_flag || branch_i.target == exp_target))
    else begin
      fail_count++;
      $error("Mismatch at %0t: branch flag, delay slot or target", $time);
    end

  assert property (@(posedge clk_i) disable iff (rst_i) op == OP_JAL && !stall_i |=>
      ex_i.link_addr == $past(pc_i) + 32'd8 && ex_i.wd == LINK_REG && ex_i.wreg)
    else begin
      fail_count++;
      $error("Mismatch at %0t: jal link address or destination", $time);
    end

  assert property (@(posedge clk_i) disable iff (rst_i) op == OP_J && !stall_i |=>
      !ex_i.wreg)
    else begin
      fail_count++;
      $error("Mismatch at %0t: j writes a register", $time);
    end

  assert property (@(posedge clk_i) stall_i == exp_stall)
    else begin
      fail_count++;
      $error("Mismatch at %0t: load-use stall level", $time);
    end

  assert property (@(posedge clk_i) stall_i |=>
      ex_i.aluop == ALU_NOP && !ex_i.wreg && !ex_i.in_delayslot)
    else begin
      fail_count++;
      $error("Mismatch at %0t: no bubble after stall", $time);
    end

  assert property (@(posedge clk_i) rst_i |=> ex_i.aluop == ALU_NOP && !ex_i.wreg)
    else begin
      fail_count++;
      $error("Mismatch at %0t: execute bundle not cleared by reset", $time);
    end

endmodule

bind id_stage id_stage_assert u_assert (
  .clk_i               (clk_i),
  .rst_i               (rst_i),
  .pc_i                (pc_i),
  .inst_i              (inst_i),
  .ex_fwd_i            (ex_fwd_i),
  .mem_fwd_i           (mem_fwd_i),
  .stall_i             (stall_o),
  .branch_i            (branch_o),
  .next_in_delayslot_i (next_in_delayslot_o),
  .ex_i                (ex_o)
);

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
  input  id_pkg::word_t    inst_i,
  output id_pkg::dec_t     dec_o,
  output id_pkg::rf_read_t rf_read_o,
  output id_pkg::word_t    imm_o,
  output id_pkg::br_kind_e br_kind_o
);
  import id_pkg::*;

  opcode_e              opcode;
  funct_e               funct;
  regimm_e              rt_sel;
  reg_addr_t            rs;
  reg_addr_t            rt;
  reg_addr_t            rd;
  logic [4:0]           shamt;
  logic [IMM_WIDTH-1:0] imm16;
  logic                 imm_type;

  assign opcode = opcode_e'(inst_i[OPCODE_LSB +: 6]);
  assign funct  = funct_e'(inst_i[5:0]);
  assign rt_sel = regimm_e'(inst_i[RT_LSB +: 5]);
  assign rs     = inst_i[RS_LSB +: 5];
  assign rt     = inst_i[RT_LSB +: 5];
  assign rd     = inst_i[RD_LSB +: 5];
  assign shamt  = inst_i[SHAMT_LSB +: 5];
  assign imm16  = inst_i[IMM_WIDTH-1:0];

  always_comb begin
    dec_o     = '{aluop: ALU_NOP, alusel: SEL_NOP, wd: NOP_REG, wreg: 1'b0};
    rf_read_o = '{re1: 1'b0, re2: 1'b0, addr1: rs, addr2: rt};
    imm_o     = '0;
    br_kind_o = BR_NONE;
    imm_type  = 1'b0;
    case (opcode)
      OP_SPECIAL: begin
        if (shamt == 5'd0) begin  // register forms need shamt zero
          case (funct)
            FN_OR:   {dec_o.aluop, dec_o.alusel} = {ALU_OR, SEL_LOGIC};
            FN_AND:  {dec_o.aluop, dec_o.alusel} = {ALU_AND, SEL_LOGIC};
            FN_XOR:  {dec_o.aluop, dec_o.alusel} = {ALU_XOR, SEL_LOGIC};
            FN_SLLV: {dec_o.aluop, dec_o.alusel} = {ALU_SLL, SEL_SHIFT};
            FN_SRLV: {dec_o.aluop, dec_o.alusel} = {ALU_SRL, SEL_SHIFT};
            FN_SRAV: {dec_o.aluop, dec_o.alusel} = {ALU_SRA, SEL_SHIFT};
            FN_SLT:  {dec_o.aluop, dec_o.alusel} = {ALU_SLT, SEL_ARITH};
            FN_ADD:  {dec_o.aluop, dec_o.alusel} = {ALU_ADD, SEL_ARITH};
            FN_ADDU: {dec_o.aluop, dec_o.alusel} = {ALU_ADDU, SEL_ARITH};
            FN_SUB:  {dec_o.aluop, dec_o.alusel} = {ALU_SUB, SEL_ARITH};
            FN_JR: begin
              {dec_o.aluop, dec_o.alusel} = {ALU_JR, SEL_JB};
              rf_read_o.re1 = 1'b1;
              br_kind_o     = BR_JR;
            end
            FN_JALR: begin
              {dec_o.aluop, dec_o.alusel} = {ALU_JALR, SEL_JB};
              dec_o.wd      = rd;
              dec_o.wreg    = 1'b1;
              rf_read_o.re1 = 1'b1;
              br_kind_o     = BR_JALR;
            end
            default: ;
          endcase
          if (dec_o.alusel inside {SEL_LOGIC, SEL_SHIFT, SEL_ARITH}) begin  // three-reg ops
            dec_o.wd      = rd;
            dec_o.wreg    = 1'b1;
            rf_read_o.re1 = 1'b1;
            rf_read_o.re2 = 1'b1;
          end
        end
      end
      OP_ORI, OP_ANDI, OP_XORI: begin
        imm_type    = 1'b1;
        dec_o.alusel = SEL_LOGIC;
        imm_o       = {16'h0, imm16};  // zero-extend
        case (opcode)
          OP_ORI:  dec_o.aluop = ALU_OR;
          OP_ANDI: dec_o.aluop = ALU_AND;
          default: dec_o.aluop = ALU_XOR;
        endcase
      end
      OP_LUI: begin
        imm_type     = 1'b1;
        dec_o.aluop  = ALU_OR;
        dec_o.alusel = SEL_LOGIC;
        imm_o        = {imm16, 16'h0};
      end
      OP_ADDI, OP_ADDIU: begin
        imm_type     = 1'b1;
        dec_o.aluop  = (opcode == OP_ADDI) ? ALU_ADDI : ALU_ADDIU;
        dec_o.alusel = SEL_ARITH;
        imm_o        = {{(32 - IMM_WIDTH){imm16[IMM_WIDTH-1]}}, imm16};
      end
      OP_J: begin
        {dec_o.aluop, dec_o.alusel} = {ALU_J, SEL_JB};
        br_kind_o = BR_J;
      end
      OP_JAL: begin
        {dec_o.aluop, dec_o.alusel} = {ALU_JAL, SEL_JB};
        dec_o.wd   = LINK_REG;
        dec_o.wreg = 1'b1;
        br_kind_o  = BR_JAL;
      end
      OP_BEQ, OP_BNE: begin
        dec_o.alusel  = SEL_JB;
        dec_o.aluop   = (opcode == OP_BEQ) ? ALU_BEQ : ALU_BNE;
        br_kind_o     = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
        rf_read_o.re1 = 1'b1;
        rf_read_o.re2 = 1'b1;
      end
      OP_BGTZ, OP_BLEZ: begin
        dec_o.alusel  = SEL_JB;
        dec_o.aluop   = (opcode == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
        br_kind_o     = (opcode == OP_BGTZ) ? BR_BGTZ : BR_BLEZ;
        rf_read_o.re1 = 1'b1;
      end
      OP_REGIMM: begin
        if (rt_sel inside {RI_BGEZ, RI_BLTZ}) begin
          dec_o.alusel  = SEL_JB;
          dec_o.aluop   = (rt_sel == RI_BGEZ) ? ALU_BGEZ : ALU_BLTZ;
          br_kind_o     = (rt_sel == RI_BGEZ) ? BR_BGEZ : BR_BLTZ;
          rf_read_o.re1 = 1'b1;
        end
      end
      OP_LW: begin
        {dec_o.aluop, dec_o.alusel} = {ALU_LW, SEL_LDST};
        dec_o.wd      = rt;
        dec_o.wreg    = 1'b1;
        rf_read_o.re1 = 1'b1;
      end
      OP_SW: begin
        {dec_o.aluop, dec_o.alusel} = {ALU_SW, SEL_LDST};
        rf_read_o.re1 = 1'b1;
        rf_read_o.re2 = 1'b1;
      end
      default: ;
    endcase

    if (imm_type) begin  // rt is the target, rs the only source
      dec_o.wd      = rt;
      dec_o.wreg    = 1'b1;
      rf_read_o.re1 = 1'b1;
    end

    // constant shifts, shamt comes in as operand 1
    if (inst_i[31:RS_LSB] == '0 && funct inside {FN_SLL, FN_SRL, FN_SRA}) begin
      dec_o.alusel  = SEL_SHIFT;
      dec_o.wd      = rd;
      dec_o.wreg    = 1'b1;
      rf_read_o.re1 = 1'b0;
      rf_read_o.re2 = 1'b1;
      imm_o         = {27'd0, shamt};
      case (funct)
        FN_SLL:  dec_o.aluop = ALU_SLL;
        FN_SRL:  dec_o.aluop = ALU_SRL;
        default: dec_o.aluop = ALU_SRA;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: operand_select.sv
`timescale 1ns/1ns
`default_nettype none

module operand_select (
  input  id_pkg::rf_read_t    rf_read_i,
  input  id_pkg::word_t       imm_i,
  input  id_pkg::word_t [1:0] rf_data_i,
  input  id_pkg::ex_fwd_t     ex_fwd_i,
  input  id_pkg::fwd_t        mem_fwd_i,
  output id_pkg::word_t       reg1_o,
  output id_pkg::word_t       reg2_o,
  output logic                stall_o
);
  import id_pkg::*;

  logic ex_is_load;
  logic hit1;
  logic hit2;

  // youngest writer wins
  function automatic word_t pick(input logic re, input reg_addr_t addr,
                                 input word_t rf_data);
    word_t val;
    if (!re) begin
      val = imm_i;
    end else if (ex_fwd_i.fwd.wreg && ex_fwd_i.fwd.wd == addr) begin
      val = ex_fwd_i.fwd.wdata;
    end else if (mem_fwd_i.wreg && mem_fwd_i.wd == addr) begin
      val = mem_fwd_i.wdata;
    end else begin
      val = rf_data;
    end
    return val;
  endfunction

  assign reg1_o = pick(rf_read_i.re1, rf_read_i.addr1, rf_data_i[0]);
  assign reg2_o = pick(rf_read_i.re2, rf_read_i.addr2, rf_data_i[1]);

  // load data not ready until mem
  assign ex_is_load = (ex_fwd_i.aluop == ALU_LW) && ex_fwd_i.fwd.wreg;
  assign hit1       = rf_read_i.re1 && (ex_fwd_i.fwd.wd == rf_read_i.addr1);
  assign hit2       = rf_read_i.re2 && (ex_fwd_i.fwd.wd == rf_read_i.addr2);
  assign stall_o    = ex_is_load && (hit1 || hit2);

endmodule

`default_nettype wire

// File: tb_id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
  import id_pkg::*;

  logic        clk = 1'b0;
  logic        rst;
  word_t       pc;
  word_t       inst;
  word_t [1:0] rf_data;
  ex_fwd_t     ex_fwd;
  fwd_t        mem_fwd;
  logic        in_delayslot;
  rf_read_t    rf_read;
  logic        stall;
  branch_t     branch;
  logic        next_ds;
  ex_ctrl_t    ex_ctrl;

  int n_rtype = 0;
  int n_imm = 0;
  int n_fwd = 0;
  int n_branch = 0;
  int n_stall = 0;
  int n_reset = 0;
  int timeouts = 0;

  funct_e  rtype_fns [13] = '{FN_OR, FN_AND, FN_XOR, FN_SLLV, FN_SRLV, FN_SRAV, FN_SLL,
                              FN_SRL, FN_SRA, FN_SLT, FN_ADD, FN_ADDU, FN_SUB};
  opcode_e imm_ops [6] = '{OP_ORI, OP_ANDI, OP_XORI, OP_ADDI, OP_ADDIU, OP_LUI};

  id_stage dut_i (
    .clk_i               (clk),
    .rst_i               (rst),
    .pc_i                (pc),
    .inst_i              (inst),
    .rf_data_i           (rf_data),
    .ex_fwd_i            (ex_fwd),
    .mem_fwd_i           (mem_fwd),
    .in_delayslot_i      (in_delayslot),
    .rf_read_o           (rf_read),
    .stall_o             (stall),
    .branch_o            (branch),
    .next_in_delayslot_o (next_ds),
    .ex_o                (ex_ctrl)
  );

  always #4 clk = ~clk;

  // register file returns base plus register number
  assign rf_data[0] = 32'h1000_0000 + {27'd0, rf_read.addr1};
  assign rf_data[1] = 32'h1000_0000 + {27'd0, rf_read.addr2};

  function automatic word_t make_rtype(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd, input logic [4:0] sh,
                                       input funct_e fn);
    return {6'd0, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t make_itype(input opcode_e op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic reg_addr_t rnd_reg();
    return 5'($urandom_range(31, 1));
  endfunction

  function automatic word_t rnd_data();
    return ($urandom_range(2, 0) == 0) ? 32'd0 : $urandom;  // zero now and then
  endfunction

  // mode 0 no forward, 1 mem only, 2 both, 3 execute only
  task automatic drive(input word_t instr, input int mode, input reg_addr_t target);
    @(negedge clk);
    in_delayslot = next_ds;
    pc           = $urandom & 32'hffff_fffc;
    inst         = instr;
    ex_fwd  = '{fwd: '{wreg: mode >= 2, wd: target, wdata: rnd_data()}, aluop: ALU_ADDU};
    mem_fwd = '{wreg: mode inside {1, 2}, wd: target, wdata: rnd_data()};
    if (mode != 0) n_fwd++;
  endtask

  task automatic wait_stall(input logic level);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (stall !== level && n < 10);
    if (stall !== level) begin
      timeouts++;
      $display("Timeout at %0t: stall_o never went to %0b", $time, level);
    end else if (level) begin
      n_stall++;
    end
  endtask

  initial begin
    word_t     instr;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      shift;
    int        errors;
    void'($urandom(32'h8b3b_2a12));
    rst          = 1'b1;
    pc           = '0;
    inst         = '0;
    ex_fwd       = '0;
    mem_fwd      = '0;
    in_delayslot = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    n_reset++;

    for (int i = 0; i < 13; i++) begin
      for (int m = 0; m < 4; m++) begin
        shift = rtype_fns[i] inside {FN_SLL, FN_SRL, FN_SRA};
        rs    = shift ? 5'd0 : rnd_reg();
        rt    = rnd_reg();
        instr = make_rtype(rs, rt, rnd_reg(), shift ? 5'($urandom) : 5'd0, rtype_fns[i]);
        drive(instr, m, shift ? rt : rs);
        n_rtype++;
      end
    end

    for (int i = 0; i < 6; i++) begin
      for (int m = 0; m < 4; m++) begin
        rs = (imm_ops[i] == OP_LUI) ? 5'd0 : rnd_reg();
        drive(make_itype(imm_ops[i], rs, rnd_reg(), 16'($urandom)), m, rs);
        n_imm++;
      end
    end

    for (int k = 0; k < 10; k++) begin
      for (int m = 0; m < 8; m++) begin
        rs = 5'($urandom_range(3, 1));  // small range so beq hits equal
        rt = 5'($urandom_range(3, 1));
        case (k)
          0: instr = make_itype(OP_BEQ, rs, rt, 16'($urandom));
          1: instr = make_itype(OP_BNE, rs, rt, 16'($urandom));
          2: instr = make_itype(OP_BGTZ, rs, 5'd0, 16'($urandom));
          3: instr = make_itype(OP_BLEZ, rs, 5'd0, 16'($urandom));
          4: instr = make_itype(OP_REGIMM, rs, RI_BGEZ, 16'($urandom));
          5: instr = make_itype(OP_REGIMM, rs, RI_BLTZ, 16'($urandom));
          6: instr = {OP_J, 26'($urandom)};
          7: instr = {OP_JAL, 26'($urandom)};
          8: instr = make_rtype(rs, 5'd0, 5'd0, 5'd0, FN_JR);
          default: instr = make_rtype(rs, 5'd0, LINK_REG, 5'd0, FN_JALR);
        endcase
        drive(instr, m % 4, rs);
        n_branch++;
      end
    end

    for (int m = 0; m < 4; m++) begin
      rs = rnd_reg();
      drive(make_itype(m[0] ? OP_SW : OP_LW, rs, rnd_reg(), 16'($urandom)), m, rs);
    end

    // load in execute hits rs or rt and inst holds until stall falls
    for (int m = 0; m < 4; m++) begin
      rs = rnd_reg();
      rt = rnd_reg();
      drive(make_rtype(rs, rt, rnd_reg(), 5'd0, FN_ADDU), 0, rs);
      ex_fwd = '{fwd: '{wreg: 1'b1, wd: m[0] ? rt : rs, wdata: $urandom}, aluop: ALU_LW};
      wait_stall(1'b1);
      @(negedge clk);
      ex_fwd = '0;
      wait_stall(1'b0);
    end

    // a store or a load without write-back never stalls
    for (int m = 0; m < 2; m++) begin
      rs = rnd_reg();
      drive(make_rtype(rs, rnd_reg(), rnd_reg(), 5'd0, FN_ADDU), 0, rs);
      ex_fwd = '{fwd: '{wreg: m[0], wd: rs, wdata: $urandom}, aluop: m[0] ? ALU_SW : ALU_LW};
      wait_stall(1'b0);
    end

    drive(32'd0, 0, 5'd0);
    repeat (2) @(negedge clk);
    errors = dut_i.u_assert.fail_count + timeouts;
    $write("reached rtype=%0d imm=%0d fwd=%0d branch=%0d stall=%0d", n_rtype, n_imm, n_fwd,
           n_branch, n_stall);
    $display(" reset=%0d timeouts=%0d errors=%0d", n_reset, timeouts, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
